// File: common/fe6_ctl_pkg.sv
// Operation kind, coefficient index and Fp2 request tag types
package fe6_ctl_pkg;

  // Fp2 coefficients per Fp6 element
  parameter int NUM_COEFF = 3;

  typedef logic [1:0] coeff_idx_t;

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fe_op_t;

  // Travels with every Fp2 request and comes back with its result
  typedef struct packed {
    fe_op_t     op;   // Selects the unit operation and the return path
    coeff_idx_t idx;  // Slot in the Fp6 result
  } fe2_tag_t;

endpackage

// File: common/fe_types_pkg.sv
// Field element widths and the Fp, Fp2 and Fp6 element types
package fe_types_pkg;

  // Width of one Fp component with the modulus below 2**FP_BITS
  parameter int FP_BITS = 16;

  typedef logic [FP_BITS-1:0] fp_t;

  // Fp2 element c0 + c1*u with c0 in the low half
  typedef struct packed {
    fp_t c1;
    fp_t c0;
  } fe2_t;

  // Fp6 element as three Fp2 coefficients with index 0 in the low bits
  typedef fe2_t [2:0] fe6_t;

endpackage

// File: fe6_addsub.f
common/fe_types_pkg.sv
common/fe6_ctl_pkg.sv
hdl/fp2_modular_addsub.sv
hdl/fe2_op_arbiter.sv
fe6_seq/fe6_coeff_issue.sv
fe6_seq/fe6_coeff_gather.sv
hdl/fe6_addsub_top.sv
verif/fe6_addsub_asserts.sv
verif/tb_fe6_addsub.sv

// File: fe6_seq/fe6_coeff_gather.sv
// Result gatherer building one Fp6 element from three indexed Fp2 results
`timescale 1ns/10ps
module fe6_coeff_gather (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_res_val,
  input  fe_types_pkg::fe2_t      i_res_z,
  input  fe6_ctl_pkg::coeff_idx_t i_res_idx,
  output logic                    o_res_rdy,
  output logic                    o_val,
  output fe_types_pkg::fe6_t      o_dat,
  input  logic                    i_rdy
);
  import fe_types_pkg::*;
  import fe6_ctl_pkg::*;

  localparam coeff_idx_t LAST_IDX = coeff_idx_t'(NUM_COEFF - 1);

  logic res_fire;

  // A finished element blocks new coefficients until it is taken,
  // which backs up the unit and then the issuers
  always_comb begin
    o_res_rdy = ~o_val;
    res_fire  = i_res_val && o_res_rdy;
  end

  // Valid flag
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else begin
      if (o_val && i_rdy) o_val <= 1'b0;
      if (res_fire && (i_res_idx == LAST_IDX)) o_val <= 1'b1;  // Element complete
    end
  end

  // Coefficient slots
  always_ff @(posedge i_clk) begin
    if (res_fire && (i_res_idx <= LAST_IDX)) begin
      o_dat[i_res_idx] <= i_res_z;
    end
  end

endmodule

// File: fe6_seq/fe6_coeff_issue.sv
// Coefficient issuer splitting one Fp6 operand pair into three tagged Fp2 requests
`timescale 1ns/10ps
module fe6_coeff_issue #(
  parameter fe6_ctl_pkg::fe_op_t OP = fe6_ctl_pkg::OP_ADD
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_val,
  input  fe_types_pkg::fe6_t    i_a,
  input  fe_types_pkg::fe6_t    i_b,
  output logic                  o_rdy,
  output logic                  o_req_val,
  output fe_types_pkg::fe2_t    o_req_x,
  output fe_types_pkg::fe2_t    o_req_y,
  output fe6_ctl_pkg::fe2_tag_t o_req_tag,
  input  logic                  i_req_rdy
);
  import fe_types_pkg::*;
  import fe6_ctl_pkg::*;

  localparam coeff_idx_t LAST_IDX = coeff_idx_t'(NUM_COEFF - 1);

  coeff_idx_t cnt;       // Coefficient currently offered
  logic       req_fire;

  // Operands stay on the input until the last pair is taken
  always_comb begin
    o_req_val     = i_val;
    o_req_x       = i_a[cnt];
    o_req_y       = i_b[cnt];
    o_req_tag.op  = OP;
    o_req_tag.idx = cnt;
    req_fire      = o_req_val && i_req_rdy;
    o_rdy         = req_fire && (cnt == LAST_IDX);  // Accept with the last pair
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt <= '0;
    end else if (req_fire) begin
      if (cnt == LAST_IDX) cnt <= '0;
      else cnt <= cnt + coeff_idx_t'(1);
    end
  end

endmodule

// File: hdl/fe2_op_arbiter.sv
// Round-robin arbiter sharing the Fp2 unit, with results returned by tag
`timescale 1ns/10ps
module fe2_op_arbiter (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_add_req_val,
  input  fe_types_pkg::fe2_t      i_add_req_x,
  input  fe_types_pkg::fe2_t      i_add_req_y,
  input  fe6_ctl_pkg::fe2_tag_t   i_add_req_tag,
  output logic                    o_add_req_rdy,
  input  logic                    i_sub_req_val,
  input  fe_types_pkg::fe2_t      i_sub_req_x,
  input  fe_types_pkg::fe2_t      i_sub_req_y,
  input  fe6_ctl_pkg::fe2_tag_t   i_sub_req_tag,
  output logic                    o_sub_req_rdy,
  output logic                    o_unit_val,
  output fe_types_pkg::fe2_t      o_unit_x,
  output fe_types_pkg::fe2_t      o_unit_y,
  output fe6_ctl_pkg::fe2_tag_t   o_unit_tag,
  input  logic                    i_unit_rdy,
  input  logic                    i_unit_val,
  input  fe_types_pkg::fe2_t      i_unit_z,
  input  fe6_ctl_pkg::fe2_tag_t   i_unit_tag,
  output logic                    o_unit_rdy,
  output logic                    o_add_res_val,
  output fe_types_pkg::fe2_t      o_add_res_z,
  output fe6_ctl_pkg::coeff_idx_t o_add_res_idx,
  input  logic                    i_add_res_rdy,
  output logic                    o_sub_res_val,
  output fe_types_pkg::fe2_t      o_sub_res_z,
  output fe6_ctl_pkg::coeff_idx_t o_sub_res_idx,
  input  logic                    i_sub_res_rdy
);
  import fe_types_pkg::*;
  import fe6_ctl_pkg::*;

  logic prio_sub;   // Sub wins the next tie
  logic hold;       // Unit stalled last cycle so the grant stays put
  logic hold_sub;
  logic gnt_sub;
  logic res_sub;

  always_comb begin
    if (hold) gnt_sub = hold_sub;
    else if (i_add_req_val && i_sub_req_val) gnt_sub = prio_sub;
    else gnt_sub = i_sub_req_val;

    o_unit_val    = gnt_sub ? i_sub_req_val : i_add_req_val;
    o_unit_x      = gnt_sub ? i_sub_req_x   : i_add_req_x;
    o_unit_y      = gnt_sub ? i_sub_req_y   : i_add_req_y;
    o_unit_tag    = gnt_sub ? i_sub_req_tag : i_add_req_tag;
    o_add_req_rdy = ~gnt_sub && i_unit_rdy;
    o_sub_req_rdy = gnt_sub && i_unit_rdy;

    // Return path picked by the operation bit of the result tag
    res_sub       = (i_unit_tag.op == OP_SUB);
    o_add_res_val = i_unit_val && ~res_sub;
    o_sub_res_val = i_unit_val && res_sub;
    o_add_res_z   = i_unit_z;
    o_sub_res_z   = i_unit_z;
    o_add_res_idx = i_unit_tag.idx;
    o_sub_res_idx = i_unit_tag.idx;
    o_unit_rdy    = res_sub ? i_sub_res_rdy : i_add_res_rdy;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prio_sub <= 1'b0;
      hold     <= 1'b0;
      hold_sub <= 1'b0;
    end else begin
      hold     <= o_unit_val && ~i_unit_rdy;
      hold_sub <= gnt_sub;
      if (o_unit_val && i_unit_rdy) prio_sub <= ~gnt_sub;  // Other side next
    end
  end

endmodule

// File: hdl/fe6_addsub_top.sv
// Fp6 add and sub top level with two issue/gather paths sharing one Fp2 unit
`timescale 1ns/10ps
module fe6_addsub_top #(
  parameter int unsigned P_MOD = 65521
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_add_val,
  input  fe_types_pkg::fe6_t i_add_a,
  input  fe_types_pkg::fe6_t i_add_b,
  output logic               o_add_rdy,
  output logic               o_add_val,
  output fe_types_pkg::fe6_t o_add_sum,
  input  logic               i_add_rdy,
  input  logic               i_sub_val,
  input  fe_types_pkg::fe6_t i_sub_a,
  input  fe_types_pkg::fe6_t i_sub_b,
  output logic               o_sub_rdy,
  output logic               o_sub_val,
  output fe_types_pkg::fe6_t o_sub_diff,
  input  logic               i_sub_rdy
);
  import fe_types_pkg::*;
  import fe6_ctl_pkg::*;

  // Issuer requests
  logic       add_req_val, add_req_rdy, sub_req_val, sub_req_rdy;
  fe2_t       add_req_x, add_req_y, sub_req_x, sub_req_y;
  fe2_tag_t   add_req_tag, sub_req_tag;

  // Shared unit in and out
  logic       unit_in_val, unit_in_rdy, unit_out_val, unit_out_rdy;
  fe2_t       unit_x, unit_y, unit_z;
  fe2_tag_t   unit_in_tag, unit_out_tag;

  // Routed results
  logic       add_res_val, add_res_rdy, sub_res_val, sub_res_rdy;
  fe2_t       add_res_z, sub_res_z;
  coeff_idx_t add_res_idx, sub_res_idx;

  fe6_coeff_issue #(.OP(OP_ADD)) u_add_issue (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(i_add_val), .i_a(i_add_a), .i_b(i_add_b), .o_rdy(o_add_rdy),
    .o_req_val(add_req_val), .o_req_x(add_req_x), .o_req_y(add_req_y),
    .o_req_tag(add_req_tag), .i_req_rdy(add_req_rdy)
  );

  fe6_coeff_issue #(.OP(OP_SUB)) u_sub_issue (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(i_sub_val), .i_a(i_sub_a), .i_b(i_sub_b), .o_rdy(o_sub_rdy),
    .o_req_val(sub_req_val), .o_req_x(sub_req_x), .o_req_y(sub_req_y),
    .o_req_tag(sub_req_tag), .i_req_rdy(sub_req_rdy)
  );

  fe2_op_arbiter u_arbiter (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_add_req_val(add_req_val), .i_add_req_x(add_req_x), .i_add_req_y(add_req_y),
    .i_add_req_tag(add_req_tag), .o_add_req_rdy(add_req_rdy),
    .i_sub_req_val(sub_req_val), .i_sub_req_x(sub_req_x), .i_sub_req_y(sub_req_y),
    .i_sub_req_tag(sub_req_tag), .o_sub_req_rdy(sub_req_rdy),
    .o_unit_val(unit_in_val), .o_unit_x(unit_x), .o_unit_y(unit_y),
    .o_unit_tag(unit_in_tag), .i_unit_rdy(unit_in_rdy),
    .i_unit_val(unit_out_val), .i_unit_z(unit_z), .i_unit_tag(unit_out_tag),
    .o_unit_rdy(unit_out_rdy),
    .o_add_res_val(add_res_val), .o_add_res_z(add_res_z), .o_add_res_idx(add_res_idx),
    .i_add_res_rdy(add_res_rdy),
    .o_sub_res_val(sub_res_val), .o_sub_res_z(sub_res_z), .o_sub_res_idx(sub_res_idx),
    .i_sub_res_rdy(sub_res_rdy)
  );

  fp2_modular_addsub #(.P_MOD(P_MOD)) u_fp2_unit (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(unit_in_val), .i_x(unit_x), .i_y(unit_y), .i_tag(unit_in_tag),
    .o_rdy(unit_in_rdy),
    .o_val(unit_out_val), .o_z(unit_z), .o_tag(unit_out_tag), .i_rdy(unit_out_rdy)
  );

  fe6_coeff_gather u_add_gather (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_res_val(add_res_val), .i_res_z(add_res_z), .i_res_idx(add_res_idx),
    .o_res_rdy(add_res_rdy),
    .o_val(o_add_val), .o_dat(o_add_sum), .i_rdy(i_add_rdy)
  );

  fe6_coeff_gather u_sub_gather (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_res_val(sub_res_val), .i_res_z(sub_res_z), .i_res_idx(sub_res_idx),
    .o_res_rdy(sub_res_rdy),
    .o_val(o_sub_val), .o_dat(o_sub_diff), .i_rdy(i_sub_rdy)
  );

endmodule

// File: hdl/fp2_modular_addsub.sv
// Fp2 modular add or subtract unit, one register stage with tag pass-through
`timescale 1ns/10ps
module fp2_modular_addsub #(
  parameter int unsigned P_MOD = 65521
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_val,
  input  fe_types_pkg::fe2_t    i_x,
  input  fe_types_pkg::fe2_t    i_y,
  input  fe6_ctl_pkg::fe2_tag_t i_tag,
  output logic                  o_rdy,
  output logic                  o_val,
  output fe_types_pkg::fe2_t    o_z,
  output fe6_ctl_pkg::fe2_tag_t o_tag,
  input  logic                  i_rdy
);
  import fe_types_pkg::*;
  import fe6_ctl_pkg::*;

  localparam logic [FP_BITS:0] MOD_EXT = (FP_BITS + 1)'(P_MOD);

  logic is_sub;
  fe2_t z_next;

  // One component with operands below P_MOD
  function automatic fp_t fp_addsub(input fp_t x, input fp_t y, input logic sub);
    logic [FP_BITS:0] sum;
    logic [FP_BITS:0] dif;
    sum = {1'b0, x} + {1'b0, y};
    dif = {1'b0, x} - {1'b0, y};
    if (sub) begin
      return dif[FP_BITS] ? fp_t'(dif + MOD_EXT) : fp_t'(dif);  // Borrow wraps by P
    end
    return (sum >= MOD_EXT) ? fp_t'(sum - MOD_EXT) : fp_t'(sum);
  endfunction

  always_comb begin
    is_sub    = (i_tag.op == OP_SUB);
    z_next.c0 = fp_addsub(i_x.c0, i_y.c0, is_sub);
    z_next.c1 = fp_addsub(i_x.c1, i_y.c1, is_sub);
    o_rdy     = ~o_val || i_rdy;  // Empty or draining this cycle
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      o_z   <= z_next;
      o_tag <= i_tag;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the Fp6 add/sub testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_fe6_addsub \
    -f fe6_addsub.f -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0

// File: verif/fe6_addsub_asserts.sv
// Bound protocol assertions for the Fp6 add/sub result and accept handshakes
`timescale 1ns/10ps
module fe6_addsub_asserts (
  input logic               i_clk,
  input logic               i_rst,
  input logic               i_add_acc,
  input logic               i_add_res_val,
  input fe_types_pkg::fe6_t i_add_res,
  input logic               i_add_res_rdy,
  input logic               i_sub_acc,
  input logic               i_sub_res_val,
  input fe_types_pkg::fe6_t i_sub_res,
  input logic               i_sub_res_rdy
);

  // A stalled sum keeps its valid and its data
  add_hold_a: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_add_res_val && !i_add_res_rdy |=> i_add_res_val && $stable(i_add_res)
  ) else $error("Add result dropped or changed while the consumer stalled");

  sub_hold_a: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_sub_res_val && !i_sub_res_rdy |=> i_sub_res_val && $stable(i_sub_res)
  ) else $error("Sub result dropped or changed while the consumer stalled");

  // Reset clears both result valids
  rst_val_a: assert property (
    @(posedge i_clk) i_rst |=> !i_add_res_val && !i_sub_res_val
  ) else $error("Result valid high during or right after reset");

  // No operation is accepted out of reset
  rst_acc_a: assert property (
    @(posedge i_clk) i_rst |=> !i_add_acc && !i_sub_acc
  ) else $error("Operation accepted during or right after reset");

endmodule

// File: verif/tb_fe6_addsub.sv
// Testbench for the Fp6 add/sub top level with reference queues and self checks
`timescale 1ns/10ps
module tb_fe6_addsub;
  import fe_types_pkg::*;
  import fe6_ctl_pkg::*;

  localparam int unsigned P_MOD = 65521;
  localparam int RST_CYCLES = 16;
  localparam int N_RAND = 20;   // Per path in the single path phases
  localparam int N_EDGE = 8;
  localparam int N_BOTH = 30;
  localparam int N_HOLD = 2;
  localparam int NUM_OPS = 2 * (N_RAND + N_EDGE + N_BOTH + N_HOLD);
  localparam int CYCLE_LIMIT = 40 * NUM_OPS + RST_CYCLES;
  localparam int DRAIN_LIMIT = 400;
  localparam logic [31:0] SEED = 32'd27;

  typedef enum logic [1:0] {RDY_LOW, RDY_HIGH, RDY_RAND} rdy_mode_t;

  logic i_clk = 1'b0;
  logic i_rst;
  logic i_add_val, o_add_rdy, o_add_val, i_add_rdy;
  logic i_sub_val, o_sub_rdy, o_sub_val, i_sub_rdy;
  fe6_t i_add_a, i_add_b, o_add_sum;
  fe6_t i_sub_a, i_sub_b, o_sub_diff;

  fe6_t        add_q[$];        // Expected sums in acceptance order
  fe6_t        sub_q[$];
  fe6_t        want;
  rdy_mode_t   rdy_mode = RDY_HIGH;
  logic [31:0] stim_rng;
  logic [31:0] rdy_rng;
  int          val_errs = 0;
  int          extra_errs = 0;
  int          miss_errs = 0;
  int          cycles = 0;

  fe6_addsub_top #(.P_MOD(P_MOD)) i_dut (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_add_val(i_add_val), .i_add_a(i_add_a), .i_add_b(i_add_b), .o_add_rdy(o_add_rdy),
    .o_add_val(o_add_val), .o_add_sum(o_add_sum), .i_add_rdy(i_add_rdy),
    .i_sub_val(i_sub_val), .i_sub_a(i_sub_a), .i_sub_b(i_sub_b), .o_sub_rdy(o_sub_rdy),
    .o_sub_val(o_sub_val), .o_sub_diff(o_sub_diff), .i_sub_rdy(i_sub_rdy)
  );

  bind fe6_addsub_top fe6_addsub_asserts u_asserts (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_add_acc(o_add_rdy), .i_add_res_val(o_add_val), .i_add_res(o_add_sum),
    .i_add_res_rdy(i_add_rdy),
    .i_sub_acc(o_sub_rdy), .i_sub_res_val(o_sub_val), .i_sub_res(o_sub_diff),
    .i_sub_res_rdy(i_sub_rdy)
  );

  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Edge mode draws only from 0, 1, P-2 and P-1
  function automatic fp_t pick_fp(input logic [31:0] r, input logic edge_vals);
    if (!edge_vals) return fp_t'(r % P_MOD);
    case (r[1:0])
      2'd0: return fp_t'(0);
      2'd1: return fp_t'(1);
      2'd2: return fp_t'(P_MOD - 2);
      default: return fp_t'(P_MOD - 1);
    endcase
  endfunction

  function automatic fp_t fp_ref(input fp_t x, input fp_t y, input logic sub);
    int unsigned r;
    if (sub) r = (P_MOD + 32'(x) - 32'(y)) % P_MOD;  // Negative difference wraps by P
    else r = (32'(x) + 32'(y)) % P_MOD;
    return fp_t'(r);
  endfunction

  function automatic fe6_t expect_fe6(input fe6_t a, input fe6_t b, input logic sub);
    fe6_t r;
    for (int k = 0; k < NUM_COEFF; k++) begin
      r[k].c0 = fp_ref(a[k].c0, b[k].c0, sub);
      r[k].c1 = fp_ref(a[k].c1, b[k].c1, sub);
    end
    return r;
  endfunction

  task automatic make_operand(input logic edge_vals, output fe6_t v);
    for (int k = 0; k < NUM_COEFF; k++) begin
      stim_rng = xorshift32(stim_rng);
      v[k].c0 = pick_fp(stim_rng, edge_vals);
      stim_rng = xorshift32(stim_rng);
      v[k].c1 = pick_fp(stim_rng, edge_vals);
    end
  endtask

  task automatic run_ops(input logic sub, input int n, input logic edge_vals);
    fe6_t a;
    fe6_t b;
    for (int i = 0; i < n; i++) begin
      make_operand(edge_vals, a);
      make_operand(edge_vals, b);
      @(negedge i_clk);
      if (sub) begin
        i_sub_val = 1'b1;
        i_sub_a = a;
        i_sub_b = b;
      end else begin
        i_add_val = 1'b1;
        i_add_a = a;
        i_add_b = b;
      end
      do @(posedge i_clk); while (!(sub ? o_sub_rdy : o_add_rdy));  // Accepted with pair 2
      if (sub) sub_q.push_back(expect_fe6(a, b, 1'b1));
      else add_q.push_back(expect_fe6(a, b, 1'b0));
    end
    @(negedge i_clk);
    if (sub) i_sub_val = 1'b0;
    else i_add_val = 1'b0;
  endtask

  // Waits for every accepted operation to come back
  task automatic drain();
    int w;
    w = 0;
    do begin
      @(posedge i_clk);
      w++;
    end while ((add_q.size() != 0 || sub_q.size() != 0) && w < DRAIN_LIMIT);
    assert (add_q.size() == 0 && sub_q.size() == 0) else begin
      $display("Results missing at %0t: %0d sums and %0d differences never arrived",
               $time, add_q.size(), sub_q.size());
      miss_errs++;
    end
  endtask

  task automatic check_fe6(input string name, input fe6_t want_v, input fe6_t got);
    assert (got == want_v) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, want_v, got);
      val_errs++;
    end
  endtask

  // Random phases drop the output side ready about one cycle in four
  initial begin
    i_add_rdy = 1'b0;
    i_sub_rdy = 1'b0;
    rdy_rng = SEED;
    forever begin
      @(negedge i_clk);
      rdy_rng = xorshift32(rdy_rng);
      i_add_rdy = (rdy_mode == RDY_HIGH) || (rdy_mode == RDY_RAND && rdy_rng[1:0] != 2'd0);
      i_sub_rdy = (rdy_mode == RDY_HIGH) || (rdy_mode == RDY_RAND && rdy_rng[9:8] != 2'd0);
    end
  end

  always @(posedge i_clk) begin
    if (!i_rst && o_add_val && i_add_rdy) begin
      assert (add_q.size() != 0) else begin
        $display("Unexpected sum at %0t with no addition pending", $time);
        extra_errs++;
      end
      if (add_q.size() != 0) begin
        want = add_q.pop_front();
        check_fe6("o_add_sum", want, o_add_sum);
      end
    end
    if (!i_rst && o_sub_val && i_sub_rdy) begin
      assert (sub_q.size() != 0) else begin
        $display("Unexpected difference at %0t with no subtraction pending", $time);
        extra_errs++;
      end
      if (sub_q.size() != 0) begin
        want = sub_q.pop_front();
        check_fe6("o_sub_diff", want, o_sub_diff);
      end
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d value, %0d unexpected, %0d missing", val_errs, extra_errs,
               miss_errs);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    i_rst = 1'b1;
    i_add_val = 1'b1;   // Offers made during reset must never be taken
    i_sub_val = 1'b1;
    i_add_a = '0;
    i_add_b = '0;
    i_sub_a = '0;
    i_sub_b = '0;
    stim_rng = SEED;
    repeat (RST_CYCLES) @(posedge i_clk);
    rdy_mode = RDY_RAND;
    @(negedge i_clk);
    i_rst = 1'b0;
    i_add_val = 1'b0;
    i_sub_val = 1'b0;

    run_ops(1'b0, N_RAND, 1'b0);      // Random sums where many wrap
    drain();
    run_ops(1'b1, N_RAND, 1'b0);      // Random differences
    drain();
    fork
      run_ops(1'b0, N_EDGE, 1'b1);
      run_ops(1'b1, N_EDGE, 1'b1);
    join
    drain();

    rdy_mode = RDY_HIGH;              // Both paths fight for the unit at full rate
    fork
      run_ops(1'b0, N_BOTH, 1'b0);
      run_ops(1'b1, N_BOTH, 1'b0);
    join
    drain();

    rdy_mode = RDY_LOW;
    fork
      run_ops(1'b0, N_HOLD, 1'b0);
      run_ops(1'b1, N_HOLD, 1'b0);
      begin
        @(posedge i_clk);
        while (!(o_add_val && o_sub_val)) @(posedge i_clk);
        repeat (12) @(posedge i_clk);  // Completed results sit under back-pressure
        rdy_mode = RDY_HIGH;
      end
    join
    drain();

    $display("Errors: %0d value, %0d unexpected, %0d missing", val_errs, extra_errs,
             miss_errs);
    if (val_errs + extra_errs + miss_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
